/* Makefile */
TOP = fetchStage2Tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f fetchStage2.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/fetchStage2Tb.sv */
`timescale 1ns/10ps

module fetchStage2Tb
  import fetchPkg::*;
();

  localparam int TestCycles = 2000;
  localparam int RandCycles = 1600;
  localparam int FillCycles = 200;
  localparam int MaxCycles  = TestCycles * 3 / 2;   // Margin over the test length.

  logic clk, rstN_i;
  logic btbHit0_i, btbHit1_i, btbHit2_i, btbHit3_i;
  logic [PcWidth-1:0] btbTarget0_i, btbTarget1_i, btbTarget2_i, btbTarget3_i;
  logic prediction0_i, prediction1_i, prediction2_i, prediction3_i;
  logic [PcWidth-1:0] pc_i, rasAddr_i, resolveTarget_i;
  logic [FetchWidth*InstWidth-1:0] instBundle_i;
  logic fs1Ready_i, stall_i, resolveEn_i, resolveTaken_i, recoverEx_i, commitCti_i;
  logic [CtiTagWidth-1:0] resolveTag_i;
  logic instValid0_o, instValid1_o, instValid2_o, instValid3_o;
  logic [PcWidth-1:0] instPc0_o, instPc1_o, instPc2_o, instPc3_o;
  logic [PcWidth-1:0] instTarget0_o, instTarget1_o, instTarget2_o, instTarget3_o;
  logic [CtiTagWidth-1:0] ctiTag0_o, ctiTag1_o, ctiTag2_o, ctiTag3_o;
  logic redirectEn_o, redirectRet_o, redirectCall_o, updateEn_o, updateTaken_o;
  logic fs2Ready_o, ctiQueueFull_o;
  logic [PcWidth-1:0] redirectTarget_o, callPc_o, updatePc_o, updateTarget_o;
  ctrlType_e updateType_o;

  // Stimulus of the current cycle.
  logic [InstWidth-1:0] inst [FetchWidth];
  logic [PcWidth-1:0]   btbTgt [FetchWidth];
  logic [FetchWidth-1:0] hit, pred;
  logic resolve, recover, commit, rTaken;
  logic [PcWidth-1:0] rTarget;
  int rTag;

  // Reference model of the bundle and the queue.
  logic [PcWidth-1:0] slotPc [FetchWidth];
  logic [PcWidth-1:0] expTarget [FetchWidth];
  logic [CtiTagWidth-1:0] expTag [FetchWidth];
  ctrlType_e mType [FetchWidth];
  logic [FetchWidth-1:0] expValid, mMark;
  logic accepted, expFull, expRedirect, expRet, expCall;
  logic [PcWidth-1:0] expRdTarget, expCallPc;
  logic [PcWidth-1:0] qPc [CtiDepth];
  logic [PcWidth-1:0] qTarget [CtiDepth];
  ctrlType_e qType [CtiDepth];
  logic qTaken [CtiDepth];
  logic qResolved [CtiDepth];
  int qHead, qTail, qCount;
  logic expUpdEn, expUpdTaken;
  logic [PcWidth-1:0] expUpdPc, expUpdTarget;
  ctrlType_e expUpdType;

  logic commitOn, recoverOn, sawFull;
  int errors = 0;
  int checks = 0;
  int cycleCount = 0;

  fetchStage2 dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= MaxCycles) begin
      $display("timeout: run did not finish within %0d cycles", MaxCycles);
      $display("tests failed");
      $finish;
    end
  end

  function automatic logic randBit(input int oneIn);
    return ($urandom % oneIn) == 0;
  endfunction

  function automatic logic [InstWidth-1:0] randInst();
    logic [InstWidth-1:0] ins;
    ins = $urandom;
    case ($urandom_range(0, 7))
      1: ins[31:26] = opAlu;
      2: ins[31:26] = opJ;
      3: ins[31:26] = opJal;
      4: ins[31:26] = opBeq;
      5: ins[31:26] = opBne;
      6: ins[31:26] = opJr;                  // Usually not through the link register.
      7: begin
        ins[31:26] = opJr;
        ins[25:21] = LinkReg;
      end
      default: ins = $urandom;
    endcase
    return ins;
  endfunction

  // Control class and static target by the encoding rules.
  function automatic void classify(input logic [InstWidth-1:0] ins, input logic [PcWidth-1:0] pc,
                                   output logic isCtrl, output ctrlType_e ty,
                                   output logic [PcWidth-1:0] tgt);
    logic [PcWidth-1:0] offs;
    offs   = {{14{ins[15]}}, ins[15:0], 2'b00};
    isCtrl = 1'b1;
    ty     = ctrlJump;
    tgt    = {pc[31:28], ins[25:0], 2'b00};
    if (ins[31:26] == opJal) ty = ctrlCall;
    else if (ins[31:26] == opBeq || ins[31:26] == opBne) begin
      ty  = ctrlCond;
      tgt = pc + 32'd4 + offs;
    end else if (ins[31:26] == opJr) begin
      ty     = ctrlRet;
      isCtrl = ins[25:21] == LinkReg;
    end else if (ins[31:26] != opJ) isCtrl = 1'b0;
    if (!isCtrl || ty == ctrlRet) tgt = '0;
  endfunction

  task automatic makeStimulus();
    int ofs;
    for (int k = 0; k < FetchWidth; k++) begin
      inst[k]   = randInst();
      btbTgt[k] = $urandom;
      hit[k]    = randBit(2);
      pred[k]   = randBit(2);
    end
    resolve = 1'b0;
    recover = 1'b0;
    rTag    = 0;
    rTarget = $urandom;
    rTaken  = randBit(2);
    if (qCount > 0 && randBit(2)) begin
      resolve = 1'b1;
      ofs     = randBit(2) ? 0 : $urandom_range(0, qCount - 1);   // Favor the head.
      rTag    = (qHead + ofs) % CtiDepth;
      recover = recoverOn && randBit(10);
    end
    commit = commitOn && qCount > 0 && qResolved[qHead] && randBit(2);
    pc_i = $urandom & 32'hFFFF_FFFC;
    rasAddr_i = $urandom;
    fs1Ready_i = !randBit(8);
    stall_i = randBit(6);
    instBundle_i = {inst[3], inst[2], inst[1], inst[0]};
    {btbHit3_i, btbHit2_i, btbHit1_i, btbHit0_i} = hit;
    {prediction3_i, prediction2_i, prediction1_i, prediction0_i} = pred;
    btbTarget0_i = btbTgt[0];
    btbTarget1_i = btbTgt[1];
    btbTarget2_i = btbTgt[2];
    btbTarget3_i = btbTgt[3];
    resolveEn_i = resolve;
    resolveTag_i = CtiTagWidth'(rTag);
    resolveTarget_i = rTarget;
    resolveTaken_i = rTaken;
    recoverEx_i = recover;
    commitCti_i = commit;
  endtask

  task automatic modelBundle();
    logic isCtrl, done;
    logic [PcWidth-1:0] tgt;
    int ofs, endK;
    done = 1'b0;
    ofs  = 0;
    endK = -1;
    for (int k = 0; k < FetchWidth; k++) begin
      slotPc[k] = pc_i + PcWidth'(k * InstBytes);
      classify(inst[k], slotPc[k], isCtrl, mType[k], tgt);
      expTarget[k] = (isCtrl && mType[k] == ctrlRet) ? rasAddr_i : tgt;
      expValid[k]  = !done;
      expTag[k]    = CtiTagWidth'(qTail + ofs);
      mMark[k]     = !done && isCtrl;
      if (mMark[k]) ofs++;
      if (!done && isCtrl && (mType[k] != ctrlCond || pred[k])) begin
        done = 1'b1;
        endK = k;
      end
    end
    expFull     = qCount > CtiDepth - FetchWidth;
    accepted    = fs1Ready_i && !stall_i && !expFull;
    expRedirect = accepted && endK >= 0 && !hit[endK];
    expRet      = expRedirect && mType[endK] == ctrlRet;
    expCall     = expRedirect && mType[endK] == ctrlCall;
    expRdTarget = expRedirect ? expTarget[endK] : '0;
    expCallPc   = expRedirect ? slotPc[endK] : '0;
  endtask

  // Queue state after the coming rising edge.
  task automatic modelEdge();
    int n, idx, rOfs;
    expUpdEn = commit;
    if (commit) begin
      expUpdPc     = qPc[qHead];
      expUpdTarget = qTarget[qHead];
      expUpdType   = qType[qHead];
      expUpdTaken  = qTaken[qHead];
    end
    n = 0;
    if (accepted && !(resolve && recover)) begin
      for (int k = 0; k < FetchWidth; k++) begin
        if (mMark[k]) begin
          idx            = (qTail + n) % CtiDepth;
          qPc[idx]       = slotPc[k];
          qType[idx]     = mType[k];
          qTarget[idx]   = hit[k] ? btbTgt[k] : expTarget[k];
          qTaken[idx]    = 1'b0;
          qResolved[idx] = 1'b0;
          n++;
        end
      end
    end
    rOfs = (rTag - qHead + CtiDepth) % CtiDepth;
    if (resolve) begin
      qTarget[rTag]   = rTarget;
      qTaken[rTag]    = rTaken;
      qResolved[rTag] = 1'b1;
    end
    if (resolve && recover) begin
      qTail  = (rTag + 1) % CtiDepth;
      qCount = rOfs + 1 - (commit ? 1 : 0);
    end else begin
      qTail  = (qTail + n) % CtiDepth;
      qCount = qCount + n - (commit ? 1 : 0);
    end
    if (commit) qHead = (qHead + 1) % CtiDepth;
  endtask

  task automatic checkSlot(input int k, input logic gotValid, input logic [PcWidth-1:0] gotPc,
                           input logic [PcWidth-1:0] gotTarget,
                           input logic [CtiTagWidth-1:0] gotTag);
    checks++;
    if (gotValid !== expValid[k] || gotPc !== slotPc[k] || gotTarget !== expTarget[k]
        || gotTag !== expTag[k]) begin
      errors++;
      $display("FAIL %0t: slot %0d valid %b/%b pc %h/%h target %h/%h tag %0d/%0d", $time, k,
               gotValid, expValid[k], gotPc, slotPc[k], gotTarget, expTarget[k], gotTag, expTag[k]);
    end
  endtask

  task automatic checkRedirect(input logic gotEn, input logic [PcWidth-1:0] gotTarget,
                               input logic gotRet, input logic gotCall,
                               input logic [PcWidth-1:0] gotCallPc);
    checks++;
    if (gotEn !== expRedirect || gotRet !== expRet || gotCall !== expCall
        || (expRedirect && (gotTarget !== expRdTarget || gotCallPc !== expCallPc))) begin
      errors++;
      $display("FAIL %0t: redirect en %b/%b ret %b/%b call %b/%b target %h/%h callPc %h/%h",
               $time, gotEn, expRedirect, gotRet, expRet, gotCall, expCall,
               gotTarget, expRdTarget, gotCallPc, expCallPc);
    end
  endtask

  task automatic checkUpdate(input logic gotEn, input logic [PcWidth-1:0] gotPc,
                             input logic [PcWidth-1:0] gotTarget, input ctrlType_e gotType,
                             input logic gotTaken);
    checks++;
    if (gotEn !== expUpdEn || (expUpdEn && (gotPc !== expUpdPc || gotTarget !== expUpdTarget
        || gotType !== expUpdType || gotTaken !== expUpdTaken))) begin
      errors++;
      $display("FAIL %0t: update en %b/%b pc %h/%h target %h/%h type %0d/%0d taken %b/%b",
               $time, gotEn, expUpdEn, gotPc, expUpdPc, gotTarget, expUpdTarget,
               gotType, expUpdType, gotTaken, expUpdTaken);
    end
  endtask

  task automatic checkFlow(input logic gotReady, input logic gotFull);
    checks++;
    if (gotReady !== (fs1Ready_i && !expFull) || gotFull !== expFull) begin
      errors++;
      $display("FAIL %0t: fs2Ready %b full %b/%b", $time, gotReady, gotFull, expFull);
    end
  endtask

  task automatic runCycle();
    @(negedge clk);
    checkUpdate(updateEn_o, updatePc_o, updateTarget_o, updateType_o, updateTaken_o);
    makeStimulus();
    modelBundle();
    #5;
    checkSlot(0, instValid0_o, instPc0_o, instTarget0_o, ctiTag0_o);
    checkSlot(1, instValid1_o, instPc1_o, instTarget1_o, ctiTag1_o);
    checkSlot(2, instValid2_o, instPc2_o, instTarget2_o, ctiTag2_o);
    checkSlot(3, instValid3_o, instPc3_o, instTarget3_o, ctiTag3_o);
    checkRedirect(redirectEn_o, redirectTarget_o, redirectRet_o, redirectCall_o, callPc_o);
    checkFlow(fs2Ready_o, ctiQueueFull_o);
    if (expFull) sawFull = 1'b1;
    modelEdge();
  endtask

  initial begin
    void'($urandom(48));
    rstN_i = 1'b0;
    {btbHit0_i, btbHit1_i, btbHit2_i, btbHit3_i} = '0;
    {prediction0_i, prediction1_i, prediction2_i, prediction3_i} = '0;
    {btbTarget0_i, btbTarget1_i, btbTarget2_i, btbTarget3_i} = '0;
    {pc_i, rasAddr_i, resolveTarget_i, instBundle_i, resolveTag_i} = '0;
    {fs1Ready_i, stall_i, resolveEn_i, resolveTaken_i, recoverEx_i, commitCti_i} = '0;
    {qHead, qTail, qCount} = '0;
    expUpdEn  = 1'b0;
    sawFull   = 1'b0;
    commitOn  = 1'b1;
    recoverOn = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstN_i = 1'b1;
    repeat (RandCycles) runCycle();
    commitOn  = 1'b0;                                // Let the queue fill up.
    recoverOn = 1'b0;
    sawFull   = 1'b0;
    repeat (FillCycles) runCycle();
    if (!sawFull) begin
      errors++;
      $display("queue never became full while commits were withheld");
    end
    commitOn  = 1'b1;
    recoverOn = 1'b1;
    repeat (TestCycles - RandCycles - FillCycles) runCycle();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) $display("all tests passed");
    else $display("tests failed");
    $finish;
  end

endmodule

/* fetchStage2.f */
rtl/fetchPkg.sv
rtl/preDecode.sv
rtl/bundleValidate.sv
rtl/ctiQueue.sv
rtl/fetchStage2.sv
bench/fetchStage2Tb.sv

/* rtl/bundleValidate.sv */
`timescale 1ns/10ps

module bundleValidate
  import fetchPkg::*;
(
  input  logic [FetchWidth-1:0] isCtrl_i,
  input  ctrlType_e             ctrlType_i [FetchWidth],
  input  logic [PcWidth-1:0]    target_i [FetchWidth],
  input  logic [PcWidth-1:0]    pc_i [FetchWidth],
  input  logic [FetchWidth-1:0] prediction_i,
  input  logic [FetchWidth-1:0] btbHit_i,
  input  logic [PcWidth-1:0]    rasAddr_i,
  input  logic                  accept_i,
  output logic [FetchWidth-1:0] instValid_o,
  output logic [PcWidth-1:0]    instTarget_o [FetchWidth],
  output logic [FetchWidth-1:0] ctrlVector_o,
  output logic                  redirectEn_o,
  output logic [PcWidth-1:0]    redirectTarget_o,
  output logic                  redirectRet_o,
  output logic                  redirectCall_o,
  output logic [PcWidth-1:0]    callPc_o
);

  logic [FetchWidth-1:0] endsBundle;
  logic [FetchWidth-1:0] isRet;
  logic                  hasEnd;
  logic [SlotWidth-1:0]  endSlot;
  ctrlType_e             endType;
  logic                  needRedirect;

  for (genvar k = 0; k < FetchWidth; k++) begin : gSlot
    // Anything but a not-taken conditional branch leaves the bundle.
    assign endsBundle[k] = isCtrl_i[k] & ((ctrlType_i[k] != ctrlCond) | prediction_i[k]);
    assign isRet[k] = isCtrl_i[k] & (ctrlType_i[k] == ctrlRet);
    assign instTarget_o[k] = isRet[k] ? rasAddr_i : target_i[k];
  end

  // Slots after the first ending slot are cut off.
  always_comb begin : findEnd
    logic found;
    found       = 1'b0;
    endSlot     = '0;
    instValid_o = '0;
    for (int k = 0; k < FetchWidth; k++) begin
      if (!found) begin
        instValid_o[k] = 1'b1;
        if (endsBundle[k]) begin
          found   = 1'b1;
          endSlot = SlotWidth'(k);
        end
      end
    end
    hasEnd = found;
  end

  // A valid control slot is either the end slot or a not-taken branch before it.
  assign ctrlVector_o = instValid_o & isCtrl_i;

  assign endType      = ctrlType_i[endSlot];
  assign needRedirect = hasEnd & ~btbHit_i[endSlot];   // BTB never saw this one.

  assign redirectEn_o     = needRedirect & accept_i;
  assign redirectTarget_o = instTarget_o[endSlot];
  assign redirectRet_o    = redirectEn_o & (endType == ctrlRet);
  assign redirectCall_o   = redirectEn_o & (endType == ctrlCall);
  assign callPc_o         = pc_i[endSlot];               // Return address base for the RAS.

  always_comb begin
    aValidRun: assert (instValid_o[0] && ((instValid_o & (instValid_o + 1'b1)) == '0))
      else $error("valid slots are not a run starting at slot 0");
  end

endmodule

/* rtl/ctiQueue.sv */
`timescale 1ns/10ps

module ctiQueue
  import fetchPkg::*;
(
  input  logic                   clk,
  input  logic                   rstN_i,
  input  logic                   allocEn_i,
  input  logic [FetchWidth-1:0]  ctrlVector_i,
  input  logic [PcWidth-1:0]     pc_i [FetchWidth],
  input  logic [PcWidth-1:0]     target_i [FetchWidth],
  input  ctrlType_e              ctrlType_i [FetchWidth],
  input  logic                   resolveEn_i,
  input  logic [CtiTagWidth-1:0] resolveTag_i,
  input  logic [PcWidth-1:0]     resolveTarget_i,
  input  logic                   resolveTaken_i,
  input  logic                   recoverEx_i,
  input  logic                   commitCti_i,
  output logic [CtiTagWidth-1:0] ctiTag0_o,
  output logic [CtiTagWidth-1:0] ctiTag1_o,
  output logic [CtiTagWidth-1:0] ctiTag2_o,
  output logic [CtiTagWidth-1:0] ctiTag3_o,
  output logic                   updateEn_o,
  output logic [PcWidth-1:0]     updatePc_o,
  output logic [PcWidth-1:0]     updateTarget_o,
  output ctrlType_e              updateType_o,
  output logic                   updateTaken_o,
  output logic                   full_o
);

  logic [PcWidth-1:0]     pcMem [CtiDepth];
  logic [PcWidth-1:0]     targetMem [CtiDepth];
  ctrlType_e              typeMem [CtiDepth];
  logic [CtiDepth-1:0]    takenMem;
  logic [CtiDepth-1:0]    resolvedMem;

  logic [CtiTagWidth-1:0] head;
  logic [CtiTagWidth-1:0] tail;
  logic [CtiCntWidth-1:0] count;

  logic [CtiTagWidth-1:0] slotTag [FetchWidth];
  logic [CtiCntWidth-1:0] allocCnt;
  logic [CtiCntWidth-1:0] allocAdd;
  logic [CtiCntWidth-1:0] commitSub;
  logic                   recover;
  logic                   doAlloc;
  logic [CtiTagWidth-1:0] resolveOfs;
  logic                   resolveLive;

  // Marked slots take consecutive tail positions in slot order.
  always_comb begin : tagGen
    logic [CtiTagWidth-1:0] ofs;
    ofs = '0;
    for (int k = 0; k < FetchWidth; k++) begin
      slotTag[k] = tail + ofs;
      ofs        = ofs + CtiTagWidth'(ctrlVector_i[k]);
    end
    allocCnt = CtiCntWidth'(ofs);
  end

  assign ctiTag0_o = slotTag[0];
  assign ctiTag1_o = slotTag[1];
  assign ctiTag2_o = slotTag[2];
  assign ctiTag3_o = slotTag[3];

  assign recover   = resolveEn_i & recoverEx_i;
  assign doAlloc   = allocEn_i & ~recover;     // Squash wins over the new bundle.
  assign allocAdd  = doAlloc ? allocCnt : '0;
  assign commitSub = CtiCntWidth'(commitCti_i);

  assign full_o = count > CtiCntWidth'(CtiDepth - FetchWidth);

  // Distance of the resolved entry from the head, valid only inside the live range.
  assign resolveOfs  = resolveTag_i - head;
  assign resolveLive = {1'b0, resolveOfs} < count;

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      head       <= '0;
      tail       <= '0;
      count      <= '0;
      updateEn_o <= 1'b0;
    end else begin
      if (commitCti_i) head <= head + 1'b1;
      if (recover) begin
        tail  <= resolveTag_i + 1'b1;
        count <= {1'b0, resolveOfs} + 1'b1 - commitSub;
      end else begin
        tail  <= tail + allocAdd[CtiTagWidth-1:0];
        count <= count + allocAdd - commitSub;
      end
      updateEn_o <= commitCti_i;
    end
  end

  always_ff @(posedge clk) begin
    if (doAlloc) begin
      for (int k = 0; k < FetchWidth; k++) begin
        if (ctrlVector_i[k]) begin
          pcMem[slotTag[k]]       <= pc_i[k];
          typeMem[slotTag[k]]     <= ctrlType_i[k];
          targetMem[slotTag[k]]   <= target_i[k];
          takenMem[slotTag[k]]    <= 1'b0;
          resolvedMem[slotTag[k]] <= 1'b0;
        end
      end
    end
    if (resolveEn_i) begin
      targetMem[resolveTag_i]   <= resolveTarget_i;
      takenMem[resolveTag_i]    <= resolveTaken_i;
      resolvedMem[resolveTag_i] <= 1'b1;
    end
  end

  // BTB update for the retired head, one cycle after commit.
  always_ff @(posedge clk) begin
    if (commitCti_i) begin
      updatePc_o     <= pcMem[head];
      updateTarget_o <= targetMem[head];
      updateType_o   <= typeMem[head];
      updateTaken_o  <= takenMem[head];
    end
  end

  aCommitResolved: assert property (@(posedge clk) disable iff (!rstN_i)
    commitCti_i |-> (count != '0) && resolvedMem[head])
    else $error("commit of an empty or unresolved head");

  aAllocNotFull: assert property (@(posedge clk) disable iff (!rstN_i)
    (allocEn_i && (ctrlVector_i != '0)) |-> !full_o)
    else $error("allocation while the queue is full");

  aResolveLive: assert property (@(posedge clk) disable iff (!rstN_i)
    resolveEn_i |-> resolveLive)
    else $error("resolve of a tag outside the live range");

endmodule

/* rtl/fetchPkg.sv */
package fetchPkg;

  localparam int PcWidth     = 32;
  localparam int InstWidth   = 32;
  localparam int FetchWidth  = 4;                  // Slots per bundle.
  localparam int SlotWidth   = $clog2(FetchWidth);
  localparam int InstBytes   = 4;                  // PC step between slots.

  localparam int CtiDepth    = 16;
  localparam int CtiTagWidth = 4;
  localparam int CtiCntWidth = CtiTagWidth + 1;    // Count must reach CtiDepth.

  // Instruction fields.
  localparam int OpcodeWidth  = 6;
  localparam int RegWidth     = 5;
  localparam int ImmWidth     = 16;
  localparam int JumpIdxWidth = 26;

  // Register jumps through this register are returns.
  localparam logic [RegWidth-1:0] LinkReg = 5'd31;

  typedef enum logic [OpcodeWidth-1:0] {
    opAlu = 6'h00,    // Any unlisted opcode decodes as ALU.
    opJ   = 6'h02,
    opJal = 6'h03,
    opBeq = 6'h04,
    opBne = 6'h05,
    opJr  = 6'h08
  } opcode_e;

  // Only ctrlCond may be predicted not taken.
  typedef enum logic [1:0] {
    ctrlRet  = 2'd0,
    ctrlCall = 2'd1,
    ctrlJump = 2'd2,
    ctrlCond = 2'd3
  } ctrlType_e;

endpackage

/* rtl/fetchStage2.sv */
`timescale 1ns/10ps

module fetchStage2
  import fetchPkg::*;
(
  input  logic                            clk,
  input  logic                            rstN_i,
  input  logic                            btbHit0_i,
  input  logic                            btbHit1_i,
  input  logic                            btbHit2_i,
  input  logic                            btbHit3_i,
  input  logic [PcWidth-1:0]              btbTarget0_i,
  input  logic [PcWidth-1:0]              btbTarget1_i,
  input  logic [PcWidth-1:0]              btbTarget2_i,
  input  logic [PcWidth-1:0]              btbTarget3_i,
  input  logic                            prediction0_i,
  input  logic                            prediction1_i,
  input  logic                            prediction2_i,
  input  logic                            prediction3_i,
  input  logic [PcWidth-1:0]              pc_i,
  input  logic [FetchWidth*InstWidth-1:0] instBundle_i,
  input  logic                            fs1Ready_i,
  input  logic                            stall_i,
  input  logic [PcWidth-1:0]              rasAddr_i,
  input  logic                            resolveEn_i,
  input  logic [CtiTagWidth-1:0]          resolveTag_i,
  input  logic [PcWidth-1:0]              resolveTarget_i,
  input  logic                            resolveTaken_i,
  input  logic                            recoverEx_i,
  input  logic                            commitCti_i,
  output logic                            instValid0_o,
  output logic                            instValid1_o,
  output logic                            instValid2_o,
  output logic                            instValid3_o,
  output logic [PcWidth-1:0]              instPc0_o,
  output logic [PcWidth-1:0]              instPc1_o,
  output logic [PcWidth-1:0]              instPc2_o,
  output logic [PcWidth-1:0]              instPc3_o,
  output logic [PcWidth-1:0]              instTarget0_o,
  output logic [PcWidth-1:0]              instTarget1_o,
  output logic [PcWidth-1:0]              instTarget2_o,
  output logic [PcWidth-1:0]              instTarget3_o,
  output logic [CtiTagWidth-1:0]          ctiTag0_o,
  output logic [CtiTagWidth-1:0]          ctiTag1_o,
  output logic [CtiTagWidth-1:0]          ctiTag2_o,
  output logic [CtiTagWidth-1:0]          ctiTag3_o,
  output logic                            redirectEn_o,
  output logic [PcWidth-1:0]              redirectTarget_o,
  output logic                            redirectRet_o,
  output logic                            redirectCall_o,
  output logic [PcWidth-1:0]              callPc_o,
  output logic                            updateEn_o,
  output logic [PcWidth-1:0]              updatePc_o,
  output logic [PcWidth-1:0]              updateTarget_o,
  output ctrlType_e                       updateType_o,
  output logic                            updateTaken_o,
  output logic                            fs2Ready_o,
  output logic                            ctiQueueFull_o
);

  logic [FetchWidth-1:0] btbHit;
  logic [FetchWidth-1:0] prediction;
  logic [PcWidth-1:0]    btbTarget [FetchWidth];
  logic [PcWidth-1:0]    slotPc [FetchWidth];
  logic [FetchWidth-1:0] isCtrl;
  ctrlType_e             ctrlType [FetchWidth];
  logic [PcWidth-1:0]    target [FetchWidth];
  logic [FetchWidth-1:0] instValid;
  logic [PcWidth-1:0]    instTarget [FetchWidth];
  logic [PcWidth-1:0]    fetchTarget [FetchWidth];
  logic [FetchWidth-1:0] ctrlVector;
  logic                  ctiFull;
  logic                  accept;

  assign btbHit       = {btbHit3_i, btbHit2_i, btbHit1_i, btbHit0_i};
  assign prediction   = {prediction3_i, prediction2_i, prediction1_i, prediction0_i};
  assign btbTarget[0] = btbTarget0_i;
  assign btbTarget[1] = btbTarget1_i;
  assign btbTarget[2] = btbTarget2_i;
  assign btbTarget[3] = btbTarget3_i;

  for (genvar k = 0; k < FetchWidth; k++) begin : gSlot
    assign slotPc[k] = pc_i + PcWidth'(k * InstBytes);

    preDecode slotDecode (
      .pc_i      (slotPc[k]),
      .inst_i    (instBundle_i[k*InstWidth +: InstWidth]),
      .isCtrl_o  (isCtrl[k]),
      .ctrlType_o(ctrlType[k]),
      .target_o  (target[k])
    );

    // The queue keeps the target fetch actually followed.
    assign fetchTarget[k] = btbHit[k] ? btbTarget[k] : instTarget[k];
  end

  assign accept         = fs1Ready_i & ~stall_i & ~ctiFull;
  assign fs2Ready_o     = fs1Ready_i & ~ctiFull;
  assign ctiQueueFull_o = ctiFull;

  bundleValidate validate (
    .isCtrl_i        (isCtrl),
    .ctrlType_i      (ctrlType),
    .target_i        (target),
    .pc_i            (slotPc),
    .prediction_i    (prediction),
    .btbHit_i        (btbHit),
    .rasAddr_i       (rasAddr_i),
    .accept_i        (accept),
    .instValid_o     (instValid),
    .instTarget_o    (instTarget),
    .ctrlVector_o    (ctrlVector),
    .redirectEn_o    (redirectEn_o),
    .redirectTarget_o(redirectTarget_o),
    .redirectRet_o   (redirectRet_o),
    .redirectCall_o  (redirectCall_o),
    .callPc_o        (callPc_o)
  );

  ctiQueue ctiq (
    .clk            (clk),
    .rstN_i         (rstN_i),
    .allocEn_i      (accept),
    .ctrlVector_i   (ctrlVector),
    .pc_i           (slotPc),
    .target_i       (fetchTarget),
    .ctrlType_i     (ctrlType),
    .resolveEn_i    (resolveEn_i),
    .resolveTag_i   (resolveTag_i),
    .resolveTarget_i(resolveTarget_i),
    .resolveTaken_i (resolveTaken_i),
    .recoverEx_i    (recoverEx_i),
    .commitCti_i    (commitCti_i),
    .ctiTag0_o      (ctiTag0_o),
    .ctiTag1_o      (ctiTag1_o),
    .ctiTag2_o      (ctiTag2_o),
    .ctiTag3_o      (ctiTag3_o),
    .updateEn_o     (updateEn_o),
    .updatePc_o     (updatePc_o),
    .updateTarget_o (updateTarget_o),
    .updateType_o   (updateType_o),
    .updateTaken_o  (updateTaken_o),
    .full_o         (ctiFull)
  );

  assign instValid0_o  = instValid[0];
  assign instValid1_o  = instValid[1];
  assign instValid2_o  = instValid[2];
  assign instValid3_o  = instValid[3];
  assign instPc0_o     = slotPc[0];
  assign instPc1_o     = slotPc[1];
  assign instPc2_o     = slotPc[2];
  assign instPc3_o     = slotPc[3];
  assign instTarget0_o = instTarget[0];
  assign instTarget1_o = instTarget[1];
  assign instTarget2_o = instTarget[2];
  assign instTarget3_o = instTarget[3];

endmodule

/* rtl/preDecode.sv */
`timescale 1ns/10ps

module preDecode
  import fetchPkg::*;
(
  input  logic [PcWidth-1:0]   pc_i,
  input  logic [InstWidth-1:0] inst_i,
  output logic                 isCtrl_o,
  output ctrlType_e            ctrlType_o,
  output logic [PcWidth-1:0]   target_o
);

  opcode_e                 opcode;
  logic [RegWidth-1:0]     rs;
  logic [ImmWidth-1:0]     offset;
  logic [JumpIdxWidth-1:0] jumpIdx;
  logic [PcWidth-1:0]      nextPc;
  logic [PcWidth-1:0]      branchTarget;
  logic [PcWidth-1:0]      jumpTarget;

  assign opcode  = opcode_e'(inst_i[InstWidth-1 -: OpcodeWidth]);
  assign rs      = inst_i[JumpIdxWidth-1 -: RegWidth];   // Bits 25:21.
  assign offset  = inst_i[ImmWidth-1:0];
  assign jumpIdx = inst_i[JumpIdxWidth-1:0];

  assign nextPc = pc_i + PcWidth'(InstBytes);

  // Word offset, sign extended and relative to the next PC.
  assign branchTarget = nextPc + {{(PcWidth-ImmWidth-2){offset[ImmWidth-1]}}, offset, 2'b00};

  assign jumpTarget = {pc_i[PcWidth-1 -: PcWidth-JumpIdxWidth-2], jumpIdx, 2'b00};

  always_comb begin
    isCtrl_o   = 1'b0;
    ctrlType_o = ctrlJump;
    target_o   = '0;
    case (opcode)
      opJ: begin
        isCtrl_o = 1'b1;
        target_o = jumpTarget;
      end
      opJal: begin
        isCtrl_o   = 1'b1;
        ctrlType_o = ctrlCall;
        target_o   = jumpTarget;
      end
      opJr: begin
        // Other register jumps are not predicted here.
        if (rs == LinkReg) begin
          isCtrl_o   = 1'b1;
          ctrlType_o = ctrlRet;             // Target comes from the RAS.
        end
      end
      opBeq, opBne: begin
        isCtrl_o   = 1'b1;
        ctrlType_o = ctrlCond;
        target_o   = branchTarget;
      end
      default: begin
        isCtrl_o = 1'b0;
      end
    endcase
  end

endmodule
